// File: common/vtl_pkg.sv
/* Laser 500 VTL shared types */
package vtl_pkg;

	// cpu address, seen as a 16K slot or as an 8-bit io port
	typedef union packed {
		struct packed {
			logic [1:0]  slot;    // selects one of four bank registers
			logic [13:0] offset;  // offset inside the 16K bank
		} mem;
		struct packed {
			logic [7:0] high;     // upper byte, ignored for ports
			logic [7:0] port;     // z80 io port number
		} io;
	} cpu_addr_u;

	typedef enum logic [2:0] {
		BUS_NONE   = 3'd0,
		BUS_MEM_RD = 3'd1,
		BUS_MEM_WR = 3'd2,
		BUS_IO_RD  = 3'd3,
		BUS_IO_WR  = 3'd4
	} bus_kind_e;

	// one decoded cpu cycle
	typedef struct packed {
		bus_kind_e   kind;
		logic        mapped_io;  // bank 2 window 0x2800-0x2fff
		logic        is_ram;     // banks 4..7 accept writes
		logic [24:0] phys_addr;  // zeros, bank, offset
		logic [7:0]  port;
		logic [7:0]  data;       // cpu DO
	} bus_op_t;

	typedef struct packed {
		logic access;   // phase 1, memory is addressed
		logic sample;   // phase 2, cpu samples DI
		logic cpu_ena;  // phase 0, cpu steps
	} beat_t;

	typedef struct packed {
		logic [7:0] hsw;  // hsync width
		logic [7:0] hbp;  // back porch
		logic [7:0] hfp;  // front porch
	} htiming_t;

	localparam logic [7:0] HSW_RESET = 8'd66;
	localparam logic [7:0] HBP_RESET = 8'd70;
	localparam logic [7:0] HFP_RESET = 8'd10;

	localparam logic [7:0] PORT_JOY0_DIR  = 8'h2B;
	localparam logic [7:0] PORT_JOY0_FIRE = 8'h27;
	localparam logic [7:0] PORT_JOY1_DIR  = 8'h2E;
	localparam logic [7:0] PORT_JOY1_FIRE = 8'h2D;
	localparam logic [7:0] PORT_BANK_BASE = 8'h40;  // 0x40..0x43
	localparam logic [7:0] PORT_HSW       = 8'hA0;
	localparam logic [7:0] PORT_HBP       = 8'hA1;
	localparam logic [7:0] PORT_HFP       = 8'hA2;

	localparam logic [13:0] IO_WIN_LO   = 14'h2800;
	localparam logic [13:0] IO_WIN_HI   = 14'h2FFF;
	localparam logic [3:0]  IO_BANK     = 4'd2;
	localparam logic [3:0]  RAM_BANK_LO = 4'd4;
	localparam logic [3:0]  RAM_BANK_HI = 4'd7;

endpackage

// File: rtl/beat_sequencer.sv
/* CPU beat sequencer */
`timescale 1ns/1ps

module beat_sequencer (
	input  logic          F14M,
	input  logic          RESET,
	input  logic          MREQ_n,
	output vtl_pkg::beat_t beat,
	output logic          CPUENA
);

	logic [1:0] phase;     // 0 step, 1 access, 2 sample, 3 idle
	logic       mreq_old;  // MREQ seen at the previous phase 3
	logic       skip;      // whole beat suppressed

	always_ff @(posedge F14M) begin
		if (RESET) begin
			phase    <= 2'd0;
			mreq_old <= 1'b0;
			skip     <= 1'b0;
			CPUENA   <= 1'b0;
		end else begin
			phase  <= phase + 2'd1;  // free running, independent of line length
			CPUENA <= beat.cpu_ena;  // one clock behind phase 0
			if (phase == 2'd3) begin
				mreq_old <= ~MREQ_n;
				skip     <= ~mreq_old & ~MREQ_n;  // rising MREQ costs one beat
			end
		end
	end

	// strobes for the consumers, all masked by skip
	always_comb begin
		beat.cpu_ena = (phase == 2'd0) && !skip;
		beat.access  = (phase == 2'd1) && !skip;
		beat.sample  = (phase == 2'd2) && !skip;
	end

endmodule

// File: bus/bus_decode.sv
/* CPU bus cycle decoder */
`timescale 1ns/1ps

module bus_decode (
	input  logic               F14M,
	input  logic               RESET,
	input  vtl_pkg::cpu_addr_u A,
	input  logic [7:0]         DO,
	input  logic               MREQ_n,
	input  logic               IORQ_n,
	input  logic               RD_n,
	input  logic               WR_n,
	input  vtl_pkg::beat_t     beat,
	output vtl_pkg::bus_op_t   op
);

	logic [3:0] bank_map [4];  // 16K bank per cpu slot
	logic [3:0] bank;          // bank of the current address
	logic [7:0] bank_idx;      // port relative to 0x40

	assign bank     = bank_map[A.mem.slot];
	assign bank_idx = op.port - vtl_pkg::PORT_BANK_BASE;

	// bank map writes, only slot 0 has a defined power-up bank
	always_ff @(posedge F14M) begin
		if (RESET) begin
			bank_map[0] <= 4'd0;
		end else if (beat.sample && op.kind == vtl_pkg::BUS_IO_WR && bank_idx < 8'd4) begin
			bank_map[bank_idx[1:0]] <= op.data[3:0];  // only the low nibble counts
		end
	end

	always_comb begin
		// request type from the strobes, memory first
		if (!MREQ_n && !RD_n) begin
			op.kind = vtl_pkg::BUS_MEM_RD;
		end else if (!MREQ_n && !WR_n) begin
			op.kind = vtl_pkg::BUS_MEM_WR;
		end else if (!IORQ_n && !RD_n) begin
			op.kind = vtl_pkg::BUS_IO_RD;
		end else if (!IORQ_n && !WR_n) begin
			op.kind = vtl_pkg::BUS_IO_WR;
		end else begin
			op.kind = vtl_pkg::BUS_NONE;  // no request active
		end

		op.phys_addr = {7'd0, bank, A.mem.offset};
		op.is_ram    = (bank >= vtl_pkg::RAM_BANK_LO) && (bank <= vtl_pkg::RAM_BANK_HI);
		op.mapped_io = (bank == vtl_pkg::IO_BANK) &&
		               (A.mem.offset >= vtl_pkg::IO_WIN_LO) &&
		               (A.mem.offset <= vtl_pkg::IO_WIN_HI);  // keyboard, cassette, buzzer
		op.port      = A.io.port;
		op.data      = DO;
	end

endmodule

// File: bus/bus_execute.sv
/* Bus side effects and timing registers */
`timescale 1ns/1ps

module bus_execute (
	input  logic               F14M,
	input  logic               RESET,
	input  vtl_pkg::beat_t     beat,
	input  vtl_pkg::bus_op_t   op,
	output logic [24:0]        sdram_addr,
	output logic [7:0]         sdram_din,
	output logic               sdram_rd,
	output logic               sdram_wr,
	output logic               BUZZER,
	output logic               CASOUT,
	output vtl_pkg::htiming_t  htiming
);

	logic is_mem;   // memory cycle of either direction
	logic ram_wr;   // write that reaches sdram

	assign is_mem = (op.kind == vtl_pkg::BUS_MEM_RD) || (op.kind == vtl_pkg::BUS_MEM_WR);
	assign ram_wr = (op.kind == vtl_pkg::BUS_MEM_WR) && op.is_ram && !op.mapped_io;

	// address and write data for the sdram
	always_ff @(posedge F14M) begin
		if (beat.access && is_mem) begin
			sdram_addr <= op.phys_addr;
		end
		if (beat.access && ram_wr) begin
			sdram_din <= op.data;
		end
	end

	always_ff @(posedge F14M) begin
		if (RESET) begin
			sdram_rd <= 1'b0;
			sdram_wr <= 1'b0;
			BUZZER   <= 1'b0;
			CASOUT   <= 1'b0;
			htiming  <= '{hsw: vtl_pkg::HSW_RESET,
			              hbp: vtl_pkg::HBP_RESET,
			              hfp: vtl_pkg::HFP_RESET};
		end else begin
			sdram_rd <= beat.access && is_mem;  // single clock read strobe

			if (beat.access) begin
				if (ram_wr) begin
					sdram_wr <= 1'b1;  // rom banks silently ignore writes
				end
				if (op.kind == vtl_pkg::BUS_MEM_WR && op.mapped_io) begin
					BUZZER <= op.data[0];
					CASOUT <= op.data[2];
				end
			end

			if (beat.sample) begin
				sdram_wr <= 1'b0;  // write ends after one clock
				if (op.kind == vtl_pkg::BUS_IO_WR) begin
					// programmable line shape
					case (op.port)
						vtl_pkg::PORT_HSW: htiming.hsw <= op.data;
						vtl_pkg::PORT_HBP: htiming.hbp <= op.data;
						vtl_pkg::PORT_HFP: htiming.hfp <= op.data;
						default: ;  // other ports handled elsewhere or unused
					endcase
				end
			end
		end
	end

endmodule

// File: bus/bus_result.sv
/* CPU read data register */
`timescale 1ns/1ps

module bus_result (
	input  logic              F14M,
	input  logic              RESET,
	input  vtl_pkg::beat_t    beat,
	input  vtl_pkg::bus_op_t  op,
	input  vtl_pkg::htiming_t htiming,
	input  logic [7:0]        sdram_dout,
	input  logic [6:0]        KD,
	input  logic              CASIN,
	input  logic [31:0]       joystick_0,
	input  logic [31:0]       joystick_1,
	output logic [7:0]        DI
);

	// ---FEWSN, active low; joystick word is right,left,down,up,fire
	function automatic logic [7:0] joy_dir(input logic [31:0] joy);
		return {3'b111, ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
	endfunction

	// second fire button only, on bit 4
	function automatic logic [7:0] joy_fire(input logic [31:0] joy);
		return {3'b111, ~joy[5], 4'hF};
	endfunction

	always_ff @(posedge F14M) begin
		if (RESET) begin
			DI <= 8'hFF;  // floating bus
		end else if (beat.sample) begin
			if (op.kind == vtl_pkg::BUS_MEM_RD) begin
				// sdram answered during the access clock
				DI <= op.mapped_io ? {CASIN, KD} : sdram_dout;
			end else if (op.kind == vtl_pkg::BUS_IO_RD) begin
				case (op.port)
					vtl_pkg::PORT_JOY0_DIR:  DI <= joy_dir(joystick_0);
					vtl_pkg::PORT_JOY0_FIRE: DI <= joy_fire(joystick_0);
					vtl_pkg::PORT_JOY1_DIR:  DI <= joy_dir(joystick_1);
					vtl_pkg::PORT_JOY1_FIRE: DI <= joy_fire(joystick_1);
					vtl_pkg::PORT_HSW:       DI <= htiming.hsw;
					vtl_pkg::PORT_HBP:       DI <= htiming.hbp;
					vtl_pkg::PORT_HFP:       DI <= htiming.hfp;
					default:                 DI <= {DI[7:1], 1'b1};  // unused port
				endcase
			end
		end
	end

endmodule

// File: rtl/sync_timing.sv
/* Horizontal and vertical sync */
`timescale 1ns/1ps

module sync_timing #(
	parameter int ACTIVE_H    = 798,  // visible width in clocks
	parameter int LINES       = 313,  // lines per frame
	parameter int VSYNC_LINES = 2     // lines with vsync low
) (
	input  logic              F14M,
	input  logic              RESET,
	input  vtl_pkg::htiming_t htiming,
	output logic              hsync,
	output logic              vsync
);

	localparam int HW = 11;               // fits 3*255 + visible width
	localparam int VW = $clog2(LINES);

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic [HW-1:0] line_end;              // last clock of a line

	assign line_end = HW'(htiming.hsw) + HW'(htiming.hbp) + HW'(ACTIVE_H)
	                + HW'(htiming.hfp) - HW'(1);

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (hcnt >= line_end) begin  // also catches a line shortened mid-count
				hcnt <= '0;
				if (vcnt == VW'(LINES - 1)) begin
					vcnt <= '0;
				end else begin
					vcnt <= vcnt + VW'(1);
				end
			end else begin
				hcnt <= hcnt + HW'(1);
			end
		end
	end

	// negative syncs at the start of line and frame
	assign hsync = ~(hcnt < HW'(htiming.hsw));
	assign vsync = ~(vcnt < VW'(VSYNC_LINES));

endmodule

// File: rtl/vtl_cpu_bus.sv
/* Laser 500 VTL bus controller */
`timescale 1ns/1ps

module vtl_cpu_bus #(
	parameter int ACTIVE_H    = 798,
	parameter int LINES       = 313,
	parameter int VSYNC_LINES = 2
) (
	input  logic        F14M,
	input  logic        RESET,
	// z80 side
	output logic        CPUENA,
	input  logic        MREQ_n,
	input  logic        IORQ_n,
	input  logic        RD_n,
	input  logic        WR_n,
	input  logic [15:0] A,
	input  logic [7:0]  DO,
	output logic [7:0]  DI,
	// keyboard, cassette, joysticks
	input  logic [6:0]  KD,
	input  logic        CASIN,
	input  logic [31:0] joystick_0,
	input  logic [31:0] joystick_1,
	// sdram
	output logic [24:0] sdram_addr,
	input  logic [7:0]  sdram_dout,
	output logic [7:0]  sdram_din,
	output logic        sdram_wr,
	output logic        sdram_rd,
	// crt and sound
	output logic        hsync,
	output logic        vsync,
	output logic        BUZZER,
	output logic        CASOUT
);

	vtl_pkg::beat_t    beat;
	vtl_pkg::bus_op_t  op;
	vtl_pkg::htiming_t htiming;

	beat_sequencer u_beat (.F14M(F14M), .RESET(RESET), .MREQ_n(MREQ_n),
		.beat(beat), .CPUENA(CPUENA));

	bus_decode u_decode (.F14M(F14M), .RESET(RESET), .A(A), .DO(DO),
		.MREQ_n(MREQ_n), .IORQ_n(IORQ_n), .RD_n(RD_n), .WR_n(WR_n),
		.beat(beat), .op(op));

	bus_execute u_execute (.F14M(F14M), .RESET(RESET), .beat(beat), .op(op),
		.sdram_addr(sdram_addr), .sdram_din(sdram_din), .sdram_rd(sdram_rd),
		.sdram_wr(sdram_wr), .BUZZER(BUZZER), .CASOUT(CASOUT), .htiming(htiming));

	bus_result u_result (.F14M(F14M), .RESET(RESET), .beat(beat), .op(op),
		.htiming(htiming), .sdram_dout(sdram_dout), .KD(KD), .CASIN(CASIN),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .DI(DI));

	sync_timing #(
		.ACTIVE_H(ACTIVE_H),
		.LINES(LINES),
		.VSYNC_LINES(VSYNC_LINES)
	) u_sync (.F14M(F14M), .RESET(RESET), .htiming(htiming),
		.hsync(hsync), .vsync(vsync));

endmodule

// File: tests/vtl_asserts.sv
/* Bus and sync checker */
`timescale 1ns/1ps

module vtl_asserts #(
	parameter int ACTIVE_H    = 798,
	parameter int VSYNC_LINES = 2
) (
	input logic        F14M,
	input logic        RESET,
	input logic        CPUENA,
	input logic        MREQ_n,
	input logic        IORQ_n,
	input logic        RD_n,
	input logic        WR_n,
	input logic [15:0] A,
	input logic [7:0]  DO,
	input logic [7:0]  DI,
	input logic [6:0]  KD,
	input logic        CASIN,
	input logic [31:0] joystick_0,
	input logic [31:0] joystick_1,
	input logic [24:0] sdram_addr,
	input logic [7:0]  sdram_din,
	input logic        sdram_rd,
	input logic        sdram_wr,
	input logic        hsync,
	input logic        vsync,
	input logic        BUZZER,
	input logic        CASOUT
);

	int err_count = 0;  // failed assertions so far

	logic [3:0] bank_s [4];   // bank map as seen on the bus
	logic [7:0] hsw_s;
	logic [7:0] hbp_s;
	logic [7:0] hfp_s;
	logic       rd_q;
	logic       wr_q;
	logic       mreq_q;
	logic       hs_q;
	logic       vs_q;
	logic [7:0] expect_di;     // predicted at the start of a read
	logic       win_wr;        // write cycle into the io window
	logic       exp_buz;
	logic       exp_cas;
	logic       ram_cyc;       // write cycle that must reach sdram
	logic       ram_hit;
	logic       mem_cyc;       // memory cycle of either direction
	logic       rd_hit;        // sdram_rd seen in this cycle
	logic       ena_seen;
	logic       mreq_fell;     // cpu cycle began since the last pulse
	logic       vs_seen;
	int         gap;           // clocks since the last CPUENA
	int         low_len;
	int         per;
	int         settle;        // hsync falls since a timing write
	int         vs_lines;
	logic [3:0] cur_bank;
	logic       in_win;
	logic       ram_bank;
	logic       rd_start;
	logic       rd_end;
	logic       wr_start;
	logic       wr_end;
	logic       tim_wr;
	logic       hs_fall;
	logic       hs_rise;
	logic       vs_fall;
	logic       vs_rise;

	assign cur_bank = bank_s[A[15:14]];
	assign in_win   = cur_bank == 4'd2 && A[13:0] >= 14'h2800 && A[13:0] <= 14'h2FFF;
	assign ram_bank = cur_bank >= 4'd4 && cur_bank <= 4'd7;
	assign rd_start = rd_q && !RD_n;
	assign rd_end   = !rd_q && RD_n;
	assign wr_start = wr_q && !WR_n;
	assign wr_end   = !wr_q && WR_n;
	assign tim_wr   = !IORQ_n && !WR_n && A[7:0] >= 8'hA0 && A[7:0] <= 8'hA2;
	assign hs_fall  = hs_q && !hsync;
	assign hs_rise  = !hs_q && hsync;
	assign vs_fall  = vs_q && !vsync;
	assign vs_rise  = !vs_q && vsync;

	// direction port, active low FEWSN
	function automatic logic [7:0] dir_byte(input logic [31:0] j);
		return {3'b111, ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
	endfunction

	function automatic logic [7:0] fire_byte(input logic [31:0] j);
		return {3'b111, ~j[5], 4'hF};
	endfunction

	function automatic logic [7:0] io_byte(input logic [7:0] port, input logic [7:0] old);
		case (port)
			8'h2B:   return dir_byte(joystick_0);
			8'h27:   return fire_byte(joystick_0);
			8'h2E:   return dir_byte(joystick_1);
			8'h2D:   return fire_byte(joystick_1);
			8'hA0:   return hsw_s;
			8'hA1:   return hbp_s;
			8'hA2:   return hfp_s;
			default: return {old[7:1], 1'b1};  // floating port
		endcase
	endfunction

	always_ff @(posedge F14M) begin
		rd_q   <= RD_n;
		wr_q   <= WR_n;
		mreq_q <= MREQ_n;
		hs_q   <= hsync;
		vs_q   <= vsync;
		if (RESET) begin
			bank_s   <= '{default: 4'd0};
			hsw_s    <= 8'd66;
			hbp_s    <= 8'd70;
			hfp_s    <= 8'd10;
			ena_seen <= 1'b0;
			mreq_fell <= 1'b0;
			gap      <= 0;
			settle   <= 0;
			vs_seen  <= 1'b0;
			win_wr   <= 1'b0;
			ram_cyc  <= 1'b0;
			ram_hit  <= 1'b0;
			mem_cyc  <= 1'b0;
			rd_hit   <= 1'b0;
		end else begin
			if (!IORQ_n && !WR_n) begin
				case (A[7:0])
					8'h40, 8'h41, 8'h42, 8'h43: bank_s[A[1:0]] <= DO[3:0];
					8'hA0: hsw_s <= DO;
					8'hA1: hbp_s <= DO;
					8'hA2: hfp_s <= DO;
					default: ;
				endcase
			end
			if (rd_start) begin
				if (!IORQ_n)
					expect_di <= io_byte(A[7:0], DI);
				else if (in_win)
					expect_di <= {CASIN, KD};
				else
					expect_di <= A[7:0] ^ 8'h5A;  // sdram model answer
			end
			if (wr_start) begin
				win_wr  <= !MREQ_n && in_win;
				ram_cyc <= !MREQ_n && ram_bank && !in_win;
				ram_hit <= 1'b0;
				exp_buz <= DO[0];
				exp_cas <= DO[2];
			end else if (sdram_wr) begin
				ram_hit <= 1'b1;
			end
			// every memory cycle addresses the sdram
			if (rd_start || wr_start) begin
				mem_cyc <= !MREQ_n;
				rd_hit  <= 1'b0;
			end else if (sdram_rd) begin
				rd_hit <= 1'b1;
			end
			// beat spacing
			if (CPUENA) begin
				gap       <= 1;
				ena_seen  <= 1'b1;
				mreq_fell <= 1'b0;
			end else begin
				gap <= gap + 1;
				if (mreq_q && !MREQ_n)
					mreq_fell <= 1'b1;
			end
			if (tim_wr)
				settle <= 0;
			else if (hs_fall && settle < 3)
				settle <= settle + 1;
			if (vs_fall) begin
				vs_lines <= 1;  // hsync falls on the same clock
				vs_seen  <= 1'b1;
			end else if (hs_fall && !vsync) begin
				vs_lines <= vs_lines + 1;
			end
		end
		low_len <= hsync ? 0 : low_len + 1;
		per     <= hs_fall ? 1 : per + 1;
	end

	a_ena_single: assert property (@(posedge F14M) disable iff (RESET)
		CPUENA |=> !CPUENA ##1 !CPUENA ##1 !CPUENA)
		else begin err_count++; $error("CPUENA pulse longer than one clock"); end

	a_ena_gap: assert property (@(posedge F14M) disable iff (RESET)
		CPUENA && ena_seen |-> gap == (mreq_fell ? 8 : 4))
		else begin err_count++; $error("FAILED %0t: CPUENA gap %0d", $time, gap); end

	a_wr_once: assert property (@(posedge F14M) disable iff (RESET)
		sdram_wr |=> !sdram_wr)
		else begin err_count++; $error("sdram_wr held for more than one clock"); end

	// strobe comes one clock after the access, the bus may be released by then
	a_wr_target: assert property (@(posedge F14M) disable iff (RESET)
		sdram_wr |-> $past(!MREQ_n && !WR_n && ram_bank && !in_win) &&
		sdram_addr == $past({7'd0, cur_bank, A[13:0]}) && sdram_din == $past(DO))
		else begin
			err_count++;
			$error("FAILED %0t: sdram write %h to %h", $time, sdram_din, sdram_addr);
		end

	a_wr_reach: assert property (@(posedge F14M) disable iff (RESET)
		wr_end && ram_cyc |-> ram_hit)
		else begin err_count++; $error("RAM bank write never reached the sdram"); end

	a_rd_once: assert property (@(posedge F14M) disable iff (RESET)
		sdram_rd |=> !sdram_rd)
		else begin err_count++; $error("sdram_rd held for more than one clock"); end

	a_rd_target: assert property (@(posedge F14M) disable iff (RESET)
		sdram_rd |-> $past(!MREQ_n && (!RD_n || !WR_n)) &&
		sdram_addr == $past({7'd0, cur_bank, A[13:0]}))
		else begin err_count++; $error("FAILED %0t: sdram read at %h", $time, sdram_addr); end

	a_rd_reach: assert property (@(posedge F14M) disable iff (RESET)
		(rd_end || wr_end) && mem_cyc |-> rd_hit)
		else begin err_count++; $error("memory cycle never raised sdram_rd"); end

	a_read: assert property (@(posedge F14M) disable iff (RESET)
		rd_end |-> DI == expect_di)
		else begin err_count++; $error("FAILED %0t: DI %h, want %h", $time, DI, expect_di); end

	a_window_wr: assert property (@(posedge F14M) disable iff (RESET)
		wr_end && win_wr |-> BUZZER == exp_buz && CASOUT == exp_cas)
		else begin err_count++; $error("FAILED %0t: BUZZER/CASOUT latch", $time); end

	a_hs_width: assert property (@(posedge F14M) disable iff (RESET)
		hs_rise && settle >= 1 |-> low_len == int'(hsw_s))
		else begin err_count++; $error("FAILED %0t: hsync low %0d", $time, low_len); end

	a_hs_period: assert property (@(posedge F14M) disable iff (RESET)
		hs_fall && settle >= 1 |->
		per == int'(hsw_s) + int'(hbp_s) + ACTIVE_H + int'(hfp_s))
		else begin err_count++; $error("FAILED %0t: line length %0d", $time, per); end

	a_vs_lines: assert property (@(posedge F14M) disable iff (RESET)
		vs_rise && vs_seen |-> vs_lines == VSYNC_LINES)
		else begin err_count++; $error("FAILED %0t: vsync lines %0d", $time, vs_lines); end

endmodule

bind vtl_cpu_bus vtl_asserts #(.ACTIVE_H(ACTIVE_H), .VSYNC_LINES(VSYNC_LINES)) u_asserts (
	.F14M(F14M), .RESET(RESET), .CPUENA(CPUENA), .MREQ_n(MREQ_n), .IORQ_n(IORQ_n),
	.RD_n(RD_n), .WR_n(WR_n), .A(A), .DO(DO), .DI(DI), .KD(KD), .CASIN(CASIN),
	.joystick_0(joystick_0), .joystick_1(joystick_1), .sdram_addr(sdram_addr),
	.sdram_din(sdram_din), .sdram_rd(sdram_rd), .sdram_wr(sdram_wr),
	.hsync(hsync), .vsync(vsync), .BUZZER(BUZZER), .CASOUT(CASOUT));

// File: tests/tb_vtl.sv
/* VTL bus controller testbench */
`timescale 1ns/1ps

module tb_vtl;

	// three short frames at the longest line, plus the bus tests
	localparam int LIMIT = 40000;

	logic        F14M;
	logic        RESET;
	logic        MREQ_n;
	logic        IORQ_n;
	logic        RD_n;
	logic        WR_n;
	logic [15:0] A;
	logic [7:0]  DO;
	logic [7:0]  DI;
	logic        CPUENA;
	logic [6:0]  KD;
	logic        CASIN;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [24:0] sdram_addr;
	logic [7:0]  sdram_dout;
	logic [7:0]  sdram_din;
	logic        sdram_wr;
	logic        sdram_rd;
	logic        hsync;
	logic        vsync;
	logic        BUZZER;
	logic        CASOUT;
	int          cycles = 0;
	int          tests = 0;
	int          err_last = 0;

	// 8 lines per frame keeps two frames short
	vtl_cpu_bus #(.LINES(8)) u_dut (.F14M(F14M), .RESET(RESET), .CPUENA(CPUENA),
		.MREQ_n(MREQ_n), .IORQ_n(IORQ_n), .RD_n(RD_n), .WR_n(WR_n), .A(A), .DO(DO),
		.DI(DI), .KD(KD), .CASIN(CASIN), .joystick_0(joystick_0), .joystick_1(joystick_1),
		.sdram_addr(sdram_addr), .sdram_dout(sdram_dout), .sdram_din(sdram_din),
		.sdram_wr(sdram_wr), .sdram_rd(sdram_rd), .hsync(hsync), .vsync(vsync),
		.BUZZER(BUZZER), .CASOUT(CASOUT));

	assign sdram_dout = sdram_addr[7:0] ^ 8'h5A;  // sdram model

	initial begin
		F14M = 1'b0;
		forever #10 F14M = ~F14M;
	end

	always @(posedge F14M) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	// one z80 cycle, held for two cpu beats
	task automatic bus_cycle(input logic io, input logic wr, input logic [15:0] addr,
	                         input logic [7:0] data);
		int seen;
		seen = 0;
		do @(negedge F14M); while (!CPUENA);  // cpu steps on the pulse
		@(posedge F14M);
		#2;
		A  = addr;
		DO = data;
		if (io) IORQ_n = 1'b0;
		else MREQ_n = 1'b0;
		if (wr) WR_n = 1'b0;
		else RD_n = 1'b0;
		while (seen < 2) begin
			@(negedge F14M);
			if (CPUENA) seen++;
		end
		@(posedge F14M);
		#2;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n   = 1'b1;
		WR_n   = 1'b1;
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(1'b0, 1'b1, addr, data);
	endtask

	task automatic mem_read(input logic [15:0] addr);
		bus_cycle(1'b0, 1'b0, addr, 8'h00);
	endtask

	// upper address byte is random, ports ignore it
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		bus_cycle(1'b1, 1'b1, {8'($urandom), port}, data);
	endtask

	task automatic io_read(input logic [7:0] port);
		bus_cycle(1'b1, 1'b0, {8'($urandom), port}, 8'h00);
	endtask

	task automatic end_test(input string name);
		int now;
		now = u_dut.u_asserts.err_count;
		tests++;
		$display("test %0d %s: %0d assertion failures", tests, name, now - err_last);
		err_last = now;
	endtask

	initial begin
		int          i;
		logic [1:0]  slot;
		logic [3:0]  bank;
		logic [15:0] addr;
		void'($urandom(32'h9eb7_1ef4));
		RESET = 1'b1;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n = 1'b1;
		WR_n = 1'b1;
		A = 16'h0000;
		DO = 8'h00;
		KD = 7'h7F;
		CASIN = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		repeat (2) @(posedge F14M);
		#2 RESET = 1'b0;

		// beat spacing with and without memory cycles
		repeat (4) mem_read({2'b00, 14'($urandom)});
		repeat (2) io_read(8'h10);
		end_test("cpu beat");

		for (i = 0; i < 8; i++) begin
			slot = 2'($urandom_range(3, 0));
			if (i % 2 == 0) bank = 4'(4 + $urandom_range(3, 0));  // force a ram bank
			else bank = 4'($urandom_range(15, 0));
			addr = {slot, 14'($urandom)};
			io_write(8'h40 + {6'd0, slot}, {4'($urandom), bank});
			mem_write(addr, 8'($urandom));
			mem_read(addr);
		end
		end_test("bank switching");

		io_write(8'h41, 8'h02);  // slot 1 onto the io bank
		repeat (3) begin
			addr = {2'd1, 14'h2800 + 14'($urandom_range(2047, 0))};
			mem_write(addr, 8'($urandom));
			KD = 7'($urandom);
			CASIN = 1'($urandom);
			mem_read(addr);
		end
		mem_write({2'd1, 14'h1000}, 8'hA5);  // rom part of bank 2
		end_test("mapped io");

		repeat (3) begin
			joystick_0 = $urandom;
			joystick_1 = $urandom;
			io_read(8'h2B);
			io_read(8'h27);
			io_read(8'h2E);
			io_read(8'h2D);
			mem_read({2'b00, 14'($urandom)});  // new old DI
			io_read(8'h10);
		end
		end_test("io ports");

		io_write(8'hA0, 8'($urandom_range(99, 20)));
		io_write(8'hA1, 8'($urandom_range(99, 20)));
		io_write(8'hA2, 8'($urandom_range(50, 5)));
		io_read(8'hA0);
		io_read(8'hA1);
		io_read(8'hA2);
		repeat (3) @(negedge vsync);  // lines of two whole frames
		end_test("sync timing");

		$display("%0d tests run, %0d assertion failures", tests, err_last);
		if (err_last == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: files.f
common/vtl_pkg.sv
rtl/beat_sequencer.sv
bus/bus_decode.sv
bus/bus_execute.sv
bus/bus_result.sv
rtl/sync_timing.sv
rtl/vtl_cpu_bus.sv
tests/vtl_asserts.sv
tests/tb_vtl.sv

// File: run.sh
#!/bin/sh
# build and run tb_vtl with Verilator, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vtl -f files.f -o vtl_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/vtl_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
